//--- src/pong_video_pkg.sv
// Video package with screen geometry, playfield layout, object sizes and colours
`default_nettype none

package pong_video_pkg;

    typedef logic [9:0]  coord_t;                      // Raster or vertical position
    typedef logic [10:0] xpos_t;                       // Horizontal object position
    typedef logic [11:0] rgb_t;                        // 4 bits per channel, b-g-r

    // ------------------------------
    // Screen and playfield
    localparam coord_t X_DIM        = 10'd640;         // Visible width
    localparam coord_t Y_DIM        = 10'd480;         // Visible height
    localparam coord_t TOP_BAR_POS  = 10'd32;          // Rows above are the score strip
    localparam coord_t TOP_BAR_W    = 10'd5;
    localparam coord_t PLAY_TOP     = TOP_BAR_POS + TOP_BAR_W;  // First playfield row
    localparam xpos_t  SIDE_BAR_W   = 11'd5;
    localparam xpos_t  SIDE_BAR_POS = xpos_t'(X_DIM) - SIDE_BAR_W - 11'd1;  // Right wall

    // ------------------------------
    // Ball and paddle
    localparam coord_t BALL_DIM     = 10'd10;          // Square ball side
    localparam xpos_t  BALL_SERVE_X = 11'd600;         // Serve column
    localparam coord_t BALL_REST_T  = (Y_DIM - PLAY_TOP) / 10'd2 + PLAY_TOP;  // Field centre
    localparam xpos_t  PADDLE_L_POS = 11'd16;
    localparam xpos_t  PADDLE_W     = 11'd5;
    localparam xpos_t  PADDLE_R_POS = PADDLE_L_POS + PADDLE_W;
    localparam coord_t PADDLE_LEN   = 10'd50;
    localparam coord_t PADDLE_SPEED = 10'd2;           // Pixels per frame
    localparam coord_t PADDLE_INIT  = BALL_REST_T - PADDLE_LEN / 10'd2;

    // ------------------------------
    // Colours
    localparam rgb_t WHITE            = 12'hFFF;
    localparam rgb_t BLACK            = 12'h000;
    localparam rgb_t BACKGROUND_COLOR = 12'h333;       // Dark grey
    localparam rgb_t BALL_COLOR       = WHITE;
    localparam rgb_t BAR_COLOR        = WHITE;
    localparam rgb_t PADDLE_COLOR     = WHITE;

endpackage

`default_nettype wire

//--- src/pong_game_pkg.sv
// Game package with screen states, level and speed types, score format and key codes
`default_nettype none

package pong_game_pkg;

    // ------------------------------
    // Screens
    typedef enum logic [1:0] {
        START = 2'd0,                                  // Title, waits for a key
        GAME  = 2'd1,                                  // Ball in play
        OVER  = 2'd2                                   // Final screen
    } screen_t;

    // ------------------------------
    // Levels and ball speeds
    typedef logic [1:0] level_t;
    localparam level_t LEVEL_EASY     = 2'd0;
    localparam level_t LEVEL_MEDIUM   = 2'd1;
    localparam level_t LEVEL_HARD     = 2'd2;
    localparam level_t LEVEL_ADAPTIVE = 2'd3;          // Speed follows the score

    typedef logic [2:0] hspeed_t;                      // Horizontal px per frame
    typedef logic [1:0] vspeed_t;                      // Vertical px per frame

    // ------------------------------
    // Balls and score
    typedef logic [1:0] balls_t;
    localparam balls_t BALLS_PER_GAME = 2'd3;

    localparam int SCORE_DIGITS = 3;
    typedef logic [SCORE_DIGITS-1:0][3:0] bcd_score_t; // Digit 0 is the units

    // ------------------------------
    // Raw key codes, active low
    localparam logic [1:0] BUTTONS_IDLE = 2'b11;
    localparam logic [1:0] BUTTON_DOWN  = 2'b10;
    localparam logic [1:0] BUTTON_UP    = 2'b01;

endpackage

`default_nettype wire

//--- src/screen_fsm.sv
// Screen sequencer with key guard timer, level latch and score clear pulse
`default_nettype none

module screen_fsm #(
    parameter int TRANS_BITS = 24                      // Guard timer width
) (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   en,
    input  logic [1:0]             buttons,            // Raw keys, active low
    input  pong_game_pkg::level_t  level_switch,
    input  pong_game_pkg::balls_t  balls_left,
    output pong_game_pkg::screen_t state,
    output pong_game_pkg::level_t  level,
    output logic                   score_clr
);
    import pong_game_pkg::*;

    screen_t               next_state;
    logic [TRANS_BITS-1:0] trans_cnt;                  // Zero once the guard has expired
    logic                  key_ok;                     // Press outside the guard window

    assign key_ok = (buttons != BUTTONS_IDLE) && (trans_cnt == '0);

    // ------------------------------
    // Next state
    always_comb begin
        case (state)
            START:   next_state = key_ok ? GAME : START;
            GAME:    next_state = (balls_left == '0) ? OVER : GAME;  // Last ball lost
            OVER:    next_state = key_ok ? START : OVER;
            default: next_state = START;
        endcase
    end

    // Leaving the over screen starts a fresh score
    assign score_clr = (state == OVER) && key_ok;

    // ------------------------------
    // State, guard timer, level
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= START;
            trans_cnt <= '0;
            level     <= LEVEL_EASY;
        end else if (en) begin
            state <= next_state;
            if (next_state != state) begin
                trans_cnt <= TRANS_BITS'(1);           // Arm guard on every transition
            end else if (trans_cnt != '0) begin
                trans_cnt <= trans_cnt + 1'b1;         // Runs until it wraps to zero
            end
            if (state == START && next_state == GAME) begin
                level <= level_switch;                 // Level fixed for the whole game
            end
        end
    end

endmodule

`default_nettype wire

//--- src/ball_motion.sv
// Ball mover with level speed table, wall and paddle bounces, misses and ball count
`default_nettype none

module ball_motion (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       en,
    input  logic                       frame_tick,
    input  pong_game_pkg::screen_t     state,
    input  pong_game_pkg::level_t      level,
    input  pong_game_pkg::bcd_score_t  score,
    input  pong_video_pkg::coord_t     paddle_t,
    input  pong_video_pkg::coord_t     paddle_b,
    output pong_video_pkg::coord_t     ball_t,
    output pong_video_pkg::coord_t     ball_b,
    output pong_video_pkg::xpos_t      ball_l,
    output pong_video_pkg::xpos_t      ball_r,
    output pong_game_pkg::balls_t      balls_left,
    output logic                       hit
);
    import pong_video_pkg::*;
    import pong_game_pkg::*;

    hspeed_t h_speed;
    vspeed_t v_speed;
    xpos_t   h_step;                                   // Speeds widened to position width
    coord_t  v_step;
    logic    dir_v;                                    // 1 = down
    logic    dir_h;                                    // 1 = right
    logic    next_dir_v;
    logic    next_dir_h;
    coord_t  next_t;
    xpos_t   next_l;
    balls_t  next_balls;

    // ------------------------------
    // Speed table
    always_comb begin
        case (level)
            LEVEL_EASY:   {h_speed, v_speed} = {3'd1, 2'd1};
            LEVEL_MEDIUM: {h_speed, v_speed} = {3'd3, 2'd2};
            LEVEL_HARD:   {h_speed, v_speed} = {3'd5, 2'd3};
            default: begin                             // Adaptive, thresholds on raw BCD
                if (score < bcd_score_t'(12'h015))      {h_speed, v_speed} = {3'd1, 2'd1};
                else if (score < bcd_score_t'(12'h035)) {h_speed, v_speed} = {3'd2, 2'd1};
                else if (score < bcd_score_t'(12'h060)) {h_speed, v_speed} = {3'd3, 2'd2};
                else if (score < bcd_score_t'(12'h100)) {h_speed, v_speed} = {3'd4, 2'd2};
                else                                    {h_speed, v_speed} = {3'd5, 2'd3};
            end
        endcase
    end

    assign h_step = xpos_t'(h_speed);
    assign v_step = coord_t'(v_speed);

    // ------------------------------
    // Next position
    always_comb begin
        next_t     = ball_t;
        next_l     = ball_l;
        next_dir_v = dir_v;
        next_dir_h = dir_h;
        next_balls = balls_left;
        hit        = 1'b0;
        if (state == GAME) begin
            if (!dir_v && ball_t < PLAY_TOP + v_step) begin
                next_t     = PLAY_TOP + PLAY_TOP + v_step - ball_t;  // Mirror off top bar
                next_dir_v = 1'b1;
            end else if (dir_v && ball_b > Y_DIM - v_step) begin
                next_t     = Y_DIM + Y_DIM - 10'd2 - v_step - ball_b - BALL_DIM;  // Floor
                next_dir_v = 1'b0;
            end else begin
                next_t = dir_v ? ball_t + v_step : ball_t - v_step;
            end

            if (!dir_h && ball_l < h_step) begin
                next_l     = BALL_SERVE_X;             // Miss, serve again
                next_balls = balls_left - 2'd1;
            end else if (!dir_h && ball_l < PADDLE_R_POS + h_step
                         && ball_b > paddle_t && ball_t < paddle_b) begin
                next_l     = PADDLE_R_POS + PADDLE_R_POS + h_step - ball_l;  // Paddle return
                next_dir_h = 1'b1;
                hit        = 1'b1;
            end else if (dir_h && ball_r > SIDE_BAR_POS - h_step) begin
                next_l     = SIDE_BAR_POS + SIDE_BAR_POS - h_step - ball_r - xpos_t'(BALL_DIM);
                next_dir_h = 1'b0;
            end else begin
                next_l = dir_h ? ball_l + h_step : ball_l - h_step;
            end
        end else begin
            next_t     = BALL_REST_T;                  // Parked for the next game
            next_l     = BALL_SERVE_X;
            next_dir_h = 1'b0;
            next_balls = BALLS_PER_GAME;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ball_t     <= '0;
            ball_l     <= '0;
            dir_v      <= 1'b0;
            dir_h      <= 1'b0;
            balls_left <= BALLS_PER_GAME;
        end else if (en && frame_tick) begin
            ball_t     <= next_t;
            ball_l     <= next_l;
            dir_v      <= next_dir_v;
            dir_h      <= next_dir_h;
            balls_left <= next_balls;
        end
    end

    assign ball_b = ball_t + BALL_DIM;
    assign ball_r = ball_l + xpos_t'(BALL_DIM);

endmodule

`default_nettype wire

//--- src/paddle_motion.sv
// Paddle mover driven by the up and down keys, clamped to the playfield
`default_nettype none

module paddle_motion (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   en,
    input  logic                   frame_tick,
    input  logic [1:0]             buttons,            // Raw keys, active low
    output pong_video_pkg::coord_t paddle_t,
    output pong_video_pkg::coord_t paddle_b
);
    import pong_video_pkg::*;
    import pong_game_pkg::*;

    coord_t next_t;

    always_comb begin
        next_t = paddle_t;                             // Hold when idle or both pressed
        if (buttons == BUTTON_DOWN) begin
            if (paddle_b > Y_DIM - 10'd1 - PADDLE_SPEED) begin
                next_t = Y_DIM - 10'd1 - PADDLE_LEN;   // Stop at the bottom edge
            end else begin
                next_t = paddle_t + PADDLE_SPEED;
            end
        end else if (buttons == BUTTON_UP) begin
            if (paddle_t < PLAY_TOP + PADDLE_SPEED) begin
                next_t = PLAY_TOP;                     // Rest under the top bar
            end else begin
                next_t = paddle_t - PADDLE_SPEED;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            paddle_t <= PADDLE_INIT;
        end else if (en && frame_tick) begin
            paddle_t <= next_t;
        end
    end

    assign paddle_b = paddle_t + PADDLE_LEN;

endmodule

`default_nettype wire

//--- src/score_board.sv
// BCD score counter with best-score register and record flag
`default_nettype none

module score_board #(
    parameter int SCORE_DIGITS_P = pong_game_pkg::SCORE_DIGITS
) (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           en,
    input  logic                           frame_tick,
    input  logic                           hit,        // Paddle return this frame
    input  logic                           score_clr,
    output logic [SCORE_DIGITS_P-1:0][3:0] score,
    output logic                           record
);

    logic [SCORE_DIGITS_P-1:0][3:0] score_inc;         // Score plus one in BCD
    logic [SCORE_DIGITS_P-1:0][3:0] best_score;
    logic                           carry;

    // ------------------------------
    // Decimal increment, ripple through digits
    always_comb begin
        score_inc = score;
        carry     = 1'b1;
        for (int i = 0; i < SCORE_DIGITS_P; i++) begin
            if (carry) begin
                if (score[i] == 4'd9) begin
                    score_inc[i] = 4'd0;               // Carry on, wraps after all nines
                end else begin
                    score_inc[i] = score[i] + 4'd1;
                    carry        = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            score <= '0;
        end else if (en) begin
            if (score_clr) begin
                score <= '0;                           // Clear wins over a hit
            end else if (hit && frame_tick) begin
                score <= score_inc;
            end
        end
    end

    // ------------------------------
    // Best score
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            best_score <= '0;
        end else if (en && score > best_score) begin
            best_score <= score;                       // BCD orders like binary
        end
    end

    assign record = (score == best_score) && (score != '0);

endmodule

`default_nettype wire

//--- src/raster_compositor.sv
// Pixel colour selection from raster position, screen state and object edges
`default_nettype none

module raster_compositor (
    input  pong_video_pkg::coord_t  h_count,
    input  pong_video_pkg::coord_t  v_count,
    input  pong_game_pkg::screen_t  state,
    input  pong_video_pkg::coord_t  ball_t,
    input  pong_video_pkg::coord_t  ball_b,
    input  pong_video_pkg::xpos_t   ball_l,
    input  pong_video_pkg::xpos_t   ball_r,
    input  pong_video_pkg::coord_t  paddle_t,
    input  pong_video_pkg::coord_t  paddle_b,
    output logic                    frame_tick,
    output pong_video_pkg::rgb_t    rgb
);
    import pong_video_pkg::*;
    import pong_game_pkg::*;

    xpos_t h_pos;                                      // Column at object width
    logic  video_on;
    logic  ball_on;
    logic  bar_on;
    logic  paddle_on;

    assign h_pos      = xpos_t'(h_count);
    assign frame_tick = (v_count == Y_DIM) && (h_count == '0);  // First blank line
    assign video_on   = (v_count < Y_DIM) && (h_count < X_DIM);

    // ------------------------------
    // Hit tests
    assign ball_on   = v_count >= ball_t && v_count < ball_b
                       && h_pos >= ball_l && h_pos < ball_r;
    assign bar_on    = (v_count >= TOP_BAR_POS && v_count < PLAY_TOP)
                       || (h_pos >= SIDE_BAR_POS && v_count >= PLAY_TOP);  // Top or wall
    assign paddle_on = v_count >= paddle_t && v_count < paddle_b
                       && h_pos >= PADDLE_L_POS && h_pos < PADDLE_R_POS;

    always_comb begin
        if (!video_on)             rgb = BLACK;
        else if (state != GAME)    rgb = BACKGROUND_COLOR;  // Start and over are blank
        else if (ball_on)          rgb = BALL_COLOR;
        else if (bar_on)           rgb = BAR_COLOR;
        else if (paddle_on)        rgb = PADDLE_COLOR;
        else                       rgb = BACKGROUND_COLOR;
    end

endmodule

`default_nettype wire

//--- src/pong_top.sv
// Paddle game core top level joining screen, motion, score and pixel blocks
`default_nettype none

module pong_top #(
    parameter int TRANS_BITS     = 24,                 // Key guard timer width
    parameter int SCORE_DIGITS_P = pong_game_pkg::SCORE_DIGITS
) (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           en,
    input  logic [1:0]                     buttons,      // Active low, 11 is idle
    input  pong_game_pkg::level_t          level_switch,
    input  pong_video_pkg::coord_t         h_count,
    input  pong_video_pkg::coord_t         v_count,
    output pong_video_pkg::rgb_t           rgb,
    output logic [SCORE_DIGITS_P-1:0][3:0] score,        // To seven-segment display
    output logic                           record
);
    import pong_video_pkg::*;
    import pong_game_pkg::*;

    screen_t state;
    level_t  level;
    logic    score_clr;
    logic    frame_tick;
    logic    hit;
    balls_t  balls_left;
    coord_t  ball_t;
    coord_t  ball_b;
    xpos_t   ball_l;
    xpos_t   ball_r;
    coord_t  paddle_t;
    coord_t  paddle_b;

    screen_fsm #(.TRANS_BITS(TRANS_BITS)) u_screen_fsm (
        .clk(clk), .arst_n(arst_n), .en(en),
        .buttons(buttons), .level_switch(level_switch), .balls_left(balls_left),
        .state(state), .level(level), .score_clr(score_clr)
    );

    ball_motion u_ball_motion (
        .clk(clk), .arst_n(arst_n), .en(en), .frame_tick(frame_tick),
        .state(state), .level(level), .score(bcd_score_t'(score)),
        .paddle_t(paddle_t), .paddle_b(paddle_b),
        .ball_t(ball_t), .ball_b(ball_b), .ball_l(ball_l), .ball_r(ball_r),
        .balls_left(balls_left), .hit(hit)
    );

    paddle_motion u_paddle_motion (
        .clk(clk), .arst_n(arst_n), .en(en), .frame_tick(frame_tick),
        .buttons(buttons), .paddle_t(paddle_t), .paddle_b(paddle_b)
    );

    score_board #(.SCORE_DIGITS_P(SCORE_DIGITS_P)) u_score_board (
        .clk(clk), .arst_n(arst_n), .en(en), .frame_tick(frame_tick),
        .hit(hit), .score_clr(score_clr), .score(score), .record(record)
    );

    raster_compositor u_raster_compositor (
        .h_count(h_count), .v_count(v_count), .state(state),
        .ball_t(ball_t), .ball_b(ball_b), .ball_l(ball_l), .ball_r(ball_r),
        .paddle_t(paddle_t), .paddle_b(paddle_b),
        .frame_tick(frame_tick), .rgb(rgb)
    );

endmodule

`default_nettype wire

//--- dv/pong_assertions.sv
// Bound checks on screen state encoding, score clear effect and ball wall bound
`default_nettype none

module pong_assertions (
    input logic                      clk,
    input logic                      arst_n,
    input logic                      en,
    input pong_game_pkg::screen_t    state,
    input logic                      score_clr,
    input pong_game_pkg::bcd_score_t score,
    input pong_video_pkg::xpos_t     ball_r
);
    timeunit 1ns;
    timeprecision 1ps;
    import pong_video_pkg::*;
    import pong_game_pkg::*;

    // ------------------------------
    // Screen sequencer
    state_legal: assert property (@(posedge clk) disable iff (!arst_n)
        state inside {START, GAME, OVER})
        else $error("Screen state holds an unused encoding");

    clear_to_start: assert property (@(posedge clk) disable iff (!arst_n)
        score_clr && en |=> state == START && score == '0)  // Fresh score on the title
        else $error("Score clear did not give the start screen with a zero score");

    // ------------------------------
    // Ball geometry
    ball_in_court: assert property (@(posedge clk) disable iff (!arst_n)
        ball_r <= SIDE_BAR_POS)                        // Wall bounce keeps it out
        else $error("Ball right edge moved into the right wall");

endmodule

// Attached at the top level, where the FSM, score and ball signals are visible
bind pong_top pong_assertions u_pong_assertions (
    .clk(clk), .arst_n(arst_n), .en(en), .state(state), .score_clr(score_clr),
    .score(score), .ball_r(ball_r)
);

`default_nettype wire

//--- dv/pong_tb.sv
// Testbench for the paddle game core with probe-pixel frames, random keys and a game model
`default_nettype none

module pong_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import pong_video_pkg::*;
    import pong_game_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 10;
    localparam int FRAME_CYCLES = 11;                  // Ten probes plus the tick
    localparam int NUM_FRAMES   = 9000;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + NUM_FRAMES * FRAME_CYCLES + 1000) * CLK_PERIOD;

    logic       clk = 1'b0;
    logic       arst_n;
    logic       en;
    logic [1:0] buttons;                               // Active low
    level_t     level_switch;
    coord_t     h_count;
    coord_t     v_count;
    rgb_t       rgb;
    bcd_score_t score;
    logic       record;

    integer     seed = 30155;
    int         run_left = 0;                          // Frames left in current key run
    logic [1:0] btn_req;
    level_t     lvl_req;

    // ------------------------------
    // Inputs the DUT sees this cycle
    coord_t     drv_h;
    coord_t     drv_v;
    logic       drv_en;
    logic [1:0] drv_btn;
    level_t     drv_lvl;

    // ------------------------------
    // Reference model state
    screen_t    m_state;
    logic [3:0] m_timer;                               // Guard timer, 4 bits here
    level_t     m_level;
    balls_t     m_balls;
    int         m_ball_t;
    int         m_ball_l;
    logic       m_dir_v;                               // 1 = down
    logic       m_dir_h;                               // 1 = right
    int         m_pad_t;
    bcd_score_t m_score;
    bcd_score_t m_best;

    pong_top #(.TRANS_BITS(4), .SCORE_DIGITS_P(SCORE_DIGITS)) UUT (
        .clk(clk), .arst_n(arst_n), .en(en),
        .buttons(buttons), .level_switch(level_switch),
        .h_count(h_count), .v_count(v_count),
        .rgb(rgb), .score(score), .record(record)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run(input string why);
        $display("TB FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic compare_rgb(input rgb_t got, input rgb_t exp);
        if (got !== exp) begin
            $display("Error at %0d ns: rgb got %h expected %h", $time, got, exp);
            abort_run("rgb mismatch");
        end
    endtask

    task automatic compare_score(input bcd_score_t got, input bcd_score_t exp);
        if (got !== exp) begin
            $display("Error at %0d ns: score got %h expected %h", $time, got, exp);
            abort_run("score mismatch");
        end
    endtask

    task automatic compare_flag(input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error at %0d ns: record got %b expected %b", $time, got, exp);
            abort_run("record mismatch");
        end
    endtask

    // Tens digit is horizontal step, units digit vertical step
    function automatic int speed_code(input level_t lv, input bcd_score_t s);
        case (lv)
            LEVEL_EASY:   return 11;
            LEVEL_MEDIUM: return 32;
            LEVEL_HARD:   return 53;
            default: begin
                if (s < 12'h015)      return 11;       // Adaptive on raw BCD
                else if (s < 12'h035) return 21;
                else if (s < 12'h060) return 32;
                else if (s < 12'h100) return 42;
                else                  return 53;
            end
        endcase
    endfunction

    function automatic bcd_score_t bcd_inc(input bcd_score_t s);
        bcd_score_t r;
        logic       carry;
        r     = s;
        carry = 1'b1;
        for (int i = 0; i < SCORE_DIGITS; i++) begin
            if (carry && r[i] == 4'd9) begin
                r[i] = 4'd0;                           // Ripple into next digit
            end else if (carry) begin
                r[i]  = r[i] + 4'd1;
                carry = 1'b0;
            end
        end
        return r;
    endfunction

    function automatic rgb_t expected_rgb(input int h, input int v);
        if (v >= int'(Y_DIM) || h >= int'(X_DIM)) return BLACK;
        if (m_state != GAME) return BACKGROUND_COLOR;
        if (v >= m_ball_t && v < m_ball_t + int'(BALL_DIM)
            && h >= m_ball_l && h < m_ball_l + int'(BALL_DIM)) return BALL_COLOR;
        if ((v >= int'(TOP_BAR_POS) && v < int'(PLAY_TOP))
            || (h >= int'(SIDE_BAR_POS) && v >= int'(PLAY_TOP))) return BAR_COLOR;
        if (v >= m_pad_t && v < m_pad_t + int'(PADDLE_LEN)
            && h >= int'(PADDLE_L_POS) && h < int'(PADDLE_R_POS)) return PADDLE_COLOR;
        return BACKGROUND_COLOR;
    endfunction

    // ------------------------------
    // Model step for one clock edge
    task automatic advance_model();
        logic    tick;
        logic    key_ok;
        logic    clr;
        logic    hit;
        screen_t nxt;
        int      hs;
        int      vs;
        int      t;
        int      l;
        if (drv_en) begin
            tick   = (drv_v == Y_DIM) && (drv_h == 10'd0);
            key_ok = (drv_btn != BUTTONS_IDLE) && (m_timer == 4'd0);
            case (m_state)
                START:   nxt = key_ok ? GAME : START;
                GAME:    nxt = (m_balls == 2'd0) ? OVER : GAME;
                default: nxt = key_ok ? START : OVER;
            endcase
            clr = (m_state == OVER) && key_ok;
            hit = 1'b0;
            if (m_score > m_best) m_best = m_score;    // Uses score before this edge
            if (tick && m_state != GAME) begin
                m_ball_t = int'(BALL_REST_T);          // Parked, serving left
                m_ball_l = int'(BALL_SERVE_X);
                m_dir_h  = 1'b0;
                m_balls  = BALLS_PER_GAME;
            end else if (tick) begin
                hs = speed_code(m_level, m_score) / 10;
                vs = speed_code(m_level, m_score) % 10;
                t  = m_ball_t;
                l  = m_ball_l;
                if (!m_dir_v && t < int'(PLAY_TOP) + vs) begin
                    t       = 2 * int'(PLAY_TOP) + vs - t;  // Mirror at bar bottom
                    m_dir_v = 1'b1;
                end else if (m_dir_v && t + int'(BALL_DIM) > int'(Y_DIM) - vs) begin
                    t       = 2 * (int'(Y_DIM) - 1) - t - vs - 2 * int'(BALL_DIM);
                    m_dir_v = 1'b0;
                end else begin
                    t = m_dir_v ? t + vs : t - vs;
                end
                if (!m_dir_h && l < hs) begin
                    l       = int'(BALL_SERVE_X);      // Miss
                    m_balls = m_balls - 2'd1;
                end else if (!m_dir_h && l < int'(PADDLE_R_POS) + hs
                             && m_ball_t + int'(BALL_DIM) > m_pad_t
                             && m_ball_t < m_pad_t + int'(PADDLE_LEN)) begin
                    l       = 2 * int'(PADDLE_R_POS) + hs - l;
                    m_dir_h = 1'b1;
                    hit     = 1'b1;
                end else if (m_dir_h && l + int'(BALL_DIM) > int'(SIDE_BAR_POS) - hs) begin
                    l       = 2 * int'(SIDE_BAR_POS) - l - hs - 2 * int'(BALL_DIM);
                    m_dir_h = 1'b0;
                end else begin
                    l = m_dir_h ? l + hs : l - hs;
                end
                m_ball_t = t;
                m_ball_l = l;
            end
            if (tick && drv_btn == BUTTON_DOWN) begin
                m_pad_t = m_pad_t + int'(PADDLE_SPEED);
                if (m_pad_t > int'(Y_DIM) - 1 - int'(PADDLE_LEN)) begin
                    m_pad_t = int'(Y_DIM) - 1 - int'(PADDLE_LEN);  // Bottom clamp
                end
            end else if (tick && drv_btn == BUTTON_UP) begin
                m_pad_t = m_pad_t - int'(PADDLE_SPEED);
                if (m_pad_t < int'(PLAY_TOP)) m_pad_t = int'(PLAY_TOP);
            end
            if (clr) m_score = '0;                     // Clear beats a hit
            else if (hit) m_score = bcd_inc(m_score);
            if (nxt != m_state) m_timer = 4'd1;
            else if (m_timer != 4'd0) m_timer = m_timer + 4'd1;
            if (m_state == START && nxt == GAME) m_level = drv_lvl;
            m_state = nxt;
        end
    endtask

    // ------------------------------
    // One clock of stimulus, then checks at the falling edge
    task automatic run_cycle(input coord_t h, input coord_t v);
        logic en_next;
        @(posedge clk);
        advance_model();
        en_next = ($unsigned($random(seed)) % 16) != 0;  // Occasional stall
        h_count      <= h;
        v_count      <= v;
        en           <= en_next;
        buttons      <= btn_req;
        level_switch <= lvl_req;
        drv_h   = h;
        drv_v   = v;
        drv_en  = en_next;
        drv_btn = btn_req;
        drv_lvl = lvl_req;
        @(negedge clk);
        compare_rgb(rgb, expected_rgb(int'(h), int'(v)));
        compare_score(score, m_score);
        compare_flag(record, (m_score == m_best) && (m_score != '0));
    endtask

    task automatic probe(input int h, input int v);
        coord_t ch;
        coord_t cv;
        ch = coord_t'(h);
        cv = coord_t'(v);
        if (cv == Y_DIM && ch == 10'd0) ch = 10'd1;    // Keep the tick out of probes
        run_cycle(ch, cv);
    endtask

    task automatic pick_key_run();
        int sel;
        sel = $unsigned($random(seed)) % 8;
        case (sel)
            0, 1, 2: btn_req = BUTTONS_IDLE;           // Idle-heavy so the ball gets past
            3, 4:    btn_req = BUTTON_DOWN;
            5, 6:    btn_req = BUTTON_UP;
            default: btn_req = 2'b00;
        endcase
        run_left = 1 + $unsigned($random(seed)) % 60;
        lvl_req  = level_t'($unsigned($random(seed)) % 4);
    endtask

    task automatic run_frame();
        int rh;
        int rv;
        rh = $unsigned($random(seed)) % 800;
        rv = $unsigned($random(seed)) % 525;
        probe(m_ball_l, m_ball_t);                     // Ball corners and just outside
        probe(m_ball_l + 9, m_ball_t + 9);
        probe(m_ball_l + 10, m_ball_t);
        probe(m_ball_l - 1, m_ball_t + 9);
        probe(int'(PADDLE_L_POS), m_pad_t);            // Paddle rows
        probe(int'(PADDLE_L_POS), m_pad_t - 1);
        probe(int'(PADDLE_R_POS) - 1, m_pad_t + 49);
        probe(int'(PADDLE_L_POS), m_pad_t + 50);
        probe(100 + rh % 400, int'(TOP_BAR_POS) + rv % int'(TOP_BAR_W));
        probe(rh, rv);                                 // Anywhere, blanking too
        run_cycle(10'd0, Y_DIM);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the frame loop finished");
        abort_run("simulation hang");
    end

    initial begin
        arst_n       = 1'b0;
        en           = 1'b0;
        buttons      = BUTTONS_IDLE;
        level_switch = LEVEL_EASY;
        h_count      = '0;
        v_count      = '0;
        btn_req      = BUTTONS_IDLE;
        lvl_req      = LEVEL_EASY;
        drv_h        = '0;
        drv_v        = '0;
        drv_en       = 1'b0;
        drv_btn      = BUTTONS_IDLE;
        drv_lvl      = LEVEL_EASY;
        m_state      = START;                          // Values right after reset
        m_timer      = 4'd0;
        m_level      = LEVEL_EASY;
        m_balls      = BALLS_PER_GAME;
        m_ball_t     = 0;
        m_ball_l     = 0;
        m_dir_v      = 1'b0;
        m_dir_h      = 1'b0;
        m_pad_t      = int'(PADDLE_INIT);
        m_score      = '0;
        m_best       = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        for (int f = 0; f < NUM_FRAMES; f++) begin
            if (run_left == 0) pick_key_run();
            run_left = run_left - 1;
            run_frame();
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
src/pong_video_pkg.sv
src/pong_game_pkg.sv
src/screen_fsm.sv
src/ball_motion.sv
src/paddle_motion.sv
src/score_board.sv
src/raster_compositor.sv
src/pong_top.sv
dv/pong_assertions.sv
dv/pong_tb.sv

//--- Makefile
TOP := pong_tb
SRCS := $(wildcard src/*.sv dv/*.sv)

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): compile.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f compile.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing --assert -Wall --top-module $(TOP) -f compile.f

clean:
	rm -rf obj_dir
